/* arrayHeap.f */
+incdir+hdl
hdl/arrayHeapPkg.sv
hdl/heapRequestIf.sv
hdl/heapAllocator.sv
hdl/heapArrayStore.sv
hdl/arrayHeap.sv
verification/arrayHeap_checker.sv
verification/arrayHeap_tb.sv

/* verification/arrayHeap_tb.sv */
// self-checking testbench with directed phases then a seeded random run
// every array is filled once after the first allocs, so reads never return X
// each result is compared one cycle after its command, at the falling edge
`timescale 1ns/1ps
`default_nettype none

module arrayHeap_tb;

  localparam int RESET_CYCLES  = 10;
  localparam int RESET_TIMEOUT = 100;  // cycles allowed for reset to drop
  localparam int RANDOM_STEPS  = 3000;

  logic                        clock;
  logic                        reset;
  arrayHeapPkg::heapAction_t   action;
  arrayHeapPkg::arrayId_t      array;
  arrayHeapPkg::elementIndex_t index;
  arrayHeapPkg::element_t      data;
  arrayHeapPkg::element_t      out;
  arrayHeapPkg::heapError_t    error;

  // --------------------------------------------------
  // reference model state
  // --------------------------------------------------
  bit                       mAlloc [arrayHeapPkg::HEAP_ARRAYS];
  int                       mStack [$];  // freed arrays with the top at the back
  int                       mFresh;      // next never used array
  int                       mSize  [arrayHeapPkg::HEAP_ARRAYS];
  arrayHeapPkg::element_t   mElem  [arrayHeapPkg::HEAP_ARRAYS][arrayHeapPkg::HEAP_LENGTH];
  arrayHeapPkg::element_t   expOut;
  arrayHeapPkg::heapError_t expError;

  integer seed;
  int     waited;

  // actions other than alloc and free are drawn evenly
  arrayHeapPkg::heapAction_t mix [12] = '{
    arrayHeapPkg::actNop, arrayHeapPkg::actWrite, arrayHeapPkg::actRead,
    arrayHeapPkg::actSize, arrayHeapPkg::actPush, arrayHeapPkg::actPop,
    arrayHeapPkg::actAdd, arrayHeapPkg::actAddAfter, arrayHeapPkg::actSubtract,
    arrayHeapPkg::actOr, arrayHeapPkg::actXor, arrayHeapPkg::actAnd
  };

  arrayHeap u_arrayHeap (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .data   (data),
    .out    (out),
    .error  (error)
  );

  bind arrayHeap arrayHeap_checker u_checker (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .out    (out),
    .error  (error)
  );

  always #5 clock = ~clock;  // 10 ns period

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

  // --------------------------------------------------
  // failure reporting and compare
  // --------------------------------------------------
  task automatic stopOnFailure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      stopOnFailure();
    end
  endtask

  task automatic checkAssertions();
    if (u_arrayHeap.u_checker.assertFailures != 0) begin
      $display("an assertion in the bound checker failed");
      stopOnFailure();
    end
  endtask

  // --------------------------------------------------
  // model of the heap command rules
  // --------------------------------------------------
  task automatic predict(input arrayHeapPkg::heapAction_t act, input int arr, input int idx,
                         input int d);
    int id;
    int old;
    int result;
    if (act == arrayHeapPkg::actNop) return;  // out and error hold
    if (act == arrayHeapPkg::actAlloc) begin
      if (mStack.size() > 0) begin
        id = mStack.pop_back();  // reuse in LIFO order
      end else if (mFresh < arrayHeapPkg::HEAP_ARRAYS) begin
        id = mFresh;
        mFresh++;
      end else begin
        expError = arrayHeapPkg::errOutOfMemory;
        return;
      end
      mAlloc[id] = 1'b1;
      mSize[id]  = 0;
      expOut     = arrayHeapPkg::element_t'(id);
      expError   = arrayHeapPkg::errNone;
      return;
    end
    if (!mAlloc[arr]) begin
      expError = arrayHeapPkg::errNotAllocated;  // second free lands here too
      return;
    end
    expError = arrayHeapPkg::errNone;
    old      = int'(mElem[arr][idx]);
    case (act)
      arrayHeapPkg::actFree: begin
        mAlloc[arr] = 1'b0;
        mStack.push_back(arr);
      end
      arrayHeapPkg::actWrite: begin
        mElem[arr][idx] = arrayHeapPkg::element_t'(d);
        if (idx >= mSize[arr]) mSize[arr] = idx + 1;
        expOut = arrayHeapPkg::element_t'(d);
      end
      arrayHeapPkg::actSize: expOut = arrayHeapPkg::element_t'(mSize[arr]);
      arrayHeapPkg::actPush: begin
        if (mSize[arr] == arrayHeapPkg::HEAP_LENGTH) begin
          expError = arrayHeapPkg::errFull;
        end else begin
          mElem[arr][mSize[arr]] = arrayHeapPkg::element_t'(d);
          mSize[arr]++;
        end
      end
      arrayHeapPkg::actPop: begin
        if (mSize[arr] == 0) begin
          expError = arrayHeapPkg::errEmpty;
        end else begin
          mSize[arr]--;
          expOut = mElem[arr][mSize[arr]];
        end
      end
      default: begin  // read and arithmetic need an index below the size
        if (idx >= mSize[arr]) begin
          expError = arrayHeapPkg::errOutOfBounds;
        end else if (act == arrayHeapPkg::actRead) begin
          expOut = mElem[arr][idx];
        end else begin
          case (act)
            arrayHeapPkg::actSubtract: result = (old - d + 4096) % 4096;
            arrayHeapPkg::actOr:       result = old | d;
            arrayHeapPkg::actXor:      result = old ^ d;
            arrayHeapPkg::actAnd:      result = old & d;
            default:                   result = (old + d) % 4096;  // add, addAfter
          endcase
          mElem[arr][idx] = arrayHeapPkg::element_t'(result);
          expOut = arrayHeapPkg::element_t'((act == arrayHeapPkg::actAddAfter) ? old : result);
        end
      end
    endcase
  endtask

  // drive one command, check the previous one, then predict this one
  task automatic step(input arrayHeapPkg::heapAction_t act, input int arr, input int idx,
                      input int d);
    @(posedge clock);
    action <= act;
    array  <= arrayHeapPkg::arrayId_t'(arr);
    index  <= arrayHeapPkg::elementIndex_t'(idx);
    data   <= arrayHeapPkg::element_t'(d);
    @(negedge clock);
    compare("out", out, expOut);
    compare("error", error, expError);
    checkAssertions();
    predict(act, arr, idx, d & 12'hfff);
  endtask

  // --------------------------------------------------
  // directed phases
  // --------------------------------------------------
  task automatic allocationOrder();
    for (int n = 0; n < 9; n++) step(arrayHeapPkg::actAlloc, 0, 0, 0);  // ninth runs out
  endtask

  task automatic fillMemory();
    for (int a = 0; a < arrayHeapPkg::HEAP_ARRAYS; a++) begin
      for (int i = 0; i < arrayHeapPkg::HEAP_LENGTH; i++) begin
        step(arrayHeapPkg::actWrite, a, i, (a * 4 + i) * 97 + 5);  // pattern per address
      end
    end
  endtask

  task automatic reuseAndDoubleFree();
    step(arrayHeapPkg::actFree, 2, 0, 0);
    step(arrayHeapPkg::actFree, 5, 0, 0);
    step(arrayHeapPkg::actAlloc, 0, 0, 0);  // gets 5
    step(arrayHeapPkg::actAlloc, 0, 0, 0);  // then 2
    step(arrayHeapPkg::actFree, 5, 0, 0);
    step(arrayHeapPkg::actFree, 5, 0, 0);   // already free
    step(arrayHeapPkg::actAlloc, 0, 0, 0);
  endtask

  task automatic writeReadSize();
    step(arrayHeapPkg::actFree, 3, 0, 0);
    step(arrayHeapPkg::actAlloc, 0, 0, 0);
    step(arrayHeapPkg::actRead, 3, 0, 0);   // empty array so out of bounds
    step(arrayHeapPkg::actWrite, 3, 1, 12'h123);
    step(arrayHeapPkg::actSize, 3, 0, 0);
    step(arrayHeapPkg::actRead, 3, 1, 0);
    step(arrayHeapPkg::actRead, 3, 2, 0);
    step(arrayHeapPkg::actWrite, 3, 0, 12'habc);
    step(arrayHeapPkg::actSize, 3, 0, 0);
  endtask

  task automatic pushPop();
    step(arrayHeapPkg::actFree, 4, 0, 0);
    step(arrayHeapPkg::actAlloc, 0, 0, 0);
    step(arrayHeapPkg::actPop, 4, 0, 0);    // empty
    for (int k = 1; k <= 5; k++) step(arrayHeapPkg::actPush, 4, 0, 12'h111 * k);  // fifth is full
    step(arrayHeapPkg::actSize, 4, 0, 0);
    for (int k = 0; k < 5; k++) step(arrayHeapPkg::actPop, 4, 0, 0);
  endtask

  task automatic elementArithmetic();
    step(arrayHeapPkg::actWrite, 3, 0, 12'hff0);
    step(arrayHeapPkg::actAdd, 3, 0, 12'h020);       // wraps to 010
    step(arrayHeapPkg::actAddAfter, 3, 0, 12'h005);
    step(arrayHeapPkg::actSubtract, 3, 0, 12'h100);  // wraps below zero
    step(arrayHeapPkg::actOr, 3, 1, 12'h0f0);
    step(arrayHeapPkg::actXor, 3, 1, 12'hfff);
    step(arrayHeapPkg::actAnd, 3, 1, 12'h0f0);
    step(arrayHeapPkg::actRead, 3, 0, 0);
    step(arrayHeapPkg::actRead, 3, 1, 0);
    step(arrayHeapPkg::actAdd, 3, 3, 12'h001);       // beyond size
  endtask

  task automatic randomRun();
    int r;
    arrayHeapPkg::heapAction_t act;
    for (int n = 0; n < RANDOM_STEPS; n++) begin
      r = $unsigned($random(seed)) % 100;
      if (r < 12) act = arrayHeapPkg::actAlloc;
      else if (r < 24) act = arrayHeapPkg::actFree;
      else act = mix[$unsigned($random(seed)) % 12];
      step(act, $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 4,
           $unsigned($random(seed)) % 4096);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    clock    = 1'b0;
    action   = arrayHeapPkg::actNop;
    array    = '0;
    index    = '0;
    data     = '0;
    seed     = 32'he6cf_2748;
    waited   = 0;
    mFresh   = 0;
    expOut   = '0;
    expError = arrayHeapPkg::errNone;
    foreach (mAlloc[i]) begin
      mAlloc[i] = 1'b0;
      mSize[i]  = 0;
    end
    while (reset !== 1'b0) begin
      @(posedge clock);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        $display("reset was never released");
        stopOnFailure();
      end
    end
    allocationOrder();
    fillMemory();
    reuseAndDoubleFree();
    writeReadSize();
    pushPop();
    elementArithmetic();
    randomRun();
    step(arrayHeapPkg::actNop, 0, 0, 0);  // flush last result
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/arrayHeap_checker.sv */
// assertions on the result registers of the array heap bound into arrayHeap
// sampled on the rising clock edge and mostly idle while reset is high
`timescale 1ns/1ps
`default_nettype none

module arrayHeap_checker (
  input wire                            clock,
  input wire                            reset,
  input wire arrayHeapPkg::heapAction_t action,
  input wire arrayHeapPkg::element_t    out,
  input wire arrayHeapPkg::heapError_t  error
);

  int unsigned assertFailures = 0; // failed assertions so far

  // --------------------------------------------------
  // result register properties
  // --------------------------------------------------
  clearedByReset: assert property (@(posedge clock) reset |=> error == arrayHeapPkg::errNone)
    else begin
      $error("error register not cleared by reset");
      assertFailures++;
    end

  // only six encodings exist
  legalError: assert property (@(posedge clock) disable iff (reset)
    error inside {arrayHeapPkg::errNone, arrayHeapPkg::errNotAllocated,
                  arrayHeapPkg::errOutOfBounds, arrayHeapPkg::errFull,
                  arrayHeapPkg::errEmpty, arrayHeapPkg::errOutOfMemory})
    else begin
      $error("error register holds an unknown encoding");
      assertFailures++;
    end

  nopHolds: assert property (@(posedge clock) disable iff (reset)
    action == arrayHeapPkg::actNop |=> $stable(out) && $stable(error))
    else begin
      $error("out or error changed after a nop");
      assertFailures++;
    end

endmodule

`default_nettype wire

/* hdl/arrayHeap.sv */
// array heap top, 8 arrays of 4 twelve bit elements, one action per clock
// out and error follow a command by exactly one cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module arrayHeap (
  input wire                              clock,
  input wire                              reset,   // synchronous, frees every array
  input wire arrayHeapPkg::heapAction_t   action,
  input wire arrayHeapPkg::arrayId_t      array,
  input wire arrayHeapPkg::elementIndex_t index,
  input wire arrayHeapPkg::element_t      data,
  output arrayHeapPkg::element_t          out,
  output arrayHeapPkg::heapError_t        error
);

  // --------------------------------------------------
  // decoded command between the two halves
  // --------------------------------------------------
  heapRequestIf request ();

  // allocation flags, free stack, allocated check
  heapAllocator u_allocator (
    .clock   (clock),
    .reset   (reset),
    .action  (action),
    .array   (array),
    .index   (index),
    .data    (data),
    .request (request.allocator)
  );

  // elements, sizes, result registers
  heapArrayStore u_store (
    .clock   (clock),
    .reset   (reset),
    .request (request.store),
    .out     (out),
    .error   (error)
  );

endmodule

`default_nettype wire

/* hdl/heapArrayStore.sv */
// element memory, array sizes and element arithmetic, result one cycle later
// a failed command or a nop leaves out and all memory untouched
// push and free do not change out, arithmetic wraps at the element width
`timescale 1ns/1ps
`default_nettype none

module heapArrayStore (
  input wire                           clock,
  input wire                           reset,
  heapRequestIf.store                  request,
  output arrayHeapPkg::element_t       out,
  output arrayHeapPkg::heapError_t     error
);

  arrayHeapPkg::element_t   memory [arrayHeapPkg::HEAP_ARRAYS][arrayHeapPkg::HEAP_LENGTH];
  arrayHeapPkg::arraySize_t sizes  [arrayHeapPkg::HEAP_ARRAYS]; // set to 0 on alloc

  arrayHeapPkg::arraySize_t curSize;   // size of target
  arrayHeapPkg::arraySize_t sizeLess;  // size after pop
  arrayHeapPkg::arraySize_t sizeMore;  // size after push
  arrayHeapPkg::element_t   curElem;   // element at index
  arrayHeapPkg::element_t   lastElem;  // element a pop returns
  arrayHeapPkg::element_t   arith;     // arithmetic result
  logic                     inBounds;

  // what this step does
  arrayHeapPkg::heapError_t    stepError;
  logic                        memWrite;
  arrayHeapPkg::elementIndex_t wrIndex;
  arrayHeapPkg::element_t      wrData;
  logic                        sizeWrite;
  arrayHeapPkg::arraySize_t    newSize;
  logic                        outWrite;
  arrayHeapPkg::element_t      outValue;

  // --------------------------------------------------
  // operands
  // --------------------------------------------------
  assign curSize  = sizes[request.target];
  assign sizeLess = curSize - 1'b1;
  assign sizeMore = curSize + 1'b1;
  assign curElem  = memory[request.target][request.index];
  assign lastElem = memory[request.target][arrayHeapPkg::elementIndex_t'(sizeLess)];
  assign inBounds = arrayHeapPkg::arraySize_t'(request.index) < curSize;

  always_comb begin
    case (request.action)
      arrayHeapPkg::actSubtract: arith = curElem - request.data;
      arrayHeapPkg::actOr:       arith = curElem | request.data;
      arrayHeapPkg::actXor:      arith = curElem ^ request.data;
      arrayHeapPkg::actAnd:      arith = curElem & request.data;
      default:                   arith = curElem + request.data; // add, addAfter
    endcase
  end

  // --------------------------------------------------
  // command decode
  // --------------------------------------------------
  always_comb begin
    stepError = arrayHeapPkg::errNone;
    memWrite  = 1'b0;
    wrIndex   = request.index;
    wrData    = request.data;
    sizeWrite = 1'b0;
    newSize   = curSize;
    outWrite  = 1'b0;
    outValue  = curElem;
    if (request.allocError != arrayHeapPkg::errNone) begin
      stepError = request.allocError;     // allocator already refused
    end else begin
      case (request.action)
        arrayHeapPkg::actAlloc: begin
          sizeWrite = 1'b1;
          newSize   = '0;                  // fresh or reused, starts empty
          outWrite  = 1'b1;
          outValue  = arrayHeapPkg::element_t'(request.target);
        end
        arrayHeapPkg::actWrite: begin
          memWrite = 1'b1;
          outWrite = 1'b1;
          outValue = request.data;
          if (!inBounds) begin
            sizeWrite = 1'b1;              // grow to index + 1
            newSize   = arrayHeapPkg::arraySize_t'(request.index) + 1'b1;
          end
        end
        arrayHeapPkg::actRead: begin
          if (!inBounds) stepError = arrayHeapPkg::errOutOfBounds;
          else outWrite = 1'b1;
        end
        arrayHeapPkg::actSize: begin
          outWrite = 1'b1;
          outValue = arrayHeapPkg::element_t'(curSize);
        end
        arrayHeapPkg::actPush: begin
          if (curSize == arrayHeapPkg::arraySize_t'(arrayHeapPkg::HEAP_LENGTH)) begin
            stepError = arrayHeapPkg::errFull;
          end else begin
            memWrite  = 1'b1;
            wrIndex   = arrayHeapPkg::elementIndex_t'(curSize); // append at end
            sizeWrite = 1'b1;
            newSize   = sizeMore;
          end
        end
        arrayHeapPkg::actPop: begin
          if (curSize == '0) begin
            stepError = arrayHeapPkg::errEmpty;
          end else begin
            sizeWrite = 1'b1;
            newSize   = sizeLess;
            outWrite  = 1'b1;
            outValue  = lastElem;
          end
        end
        arrayHeapPkg::actAdd, arrayHeapPkg::actAddAfter, arrayHeapPkg::actSubtract,
        arrayHeapPkg::actOr, arrayHeapPkg::actXor, arrayHeapPkg::actAnd: begin
          if (!inBounds) begin
            stepError = arrayHeapPkg::errOutOfBounds;
          end else begin
            memWrite = 1'b1;
            wrData   = arith;             // write back in place
            outWrite = 1'b1;
            outValue = (request.action == arrayHeapPkg::actAddAfter) ? curElem : arith;
          end
        end
        default: ;                        // nop and free, nothing stored here
      endcase
    end
  end

  // --------------------------------------------------
  // storage and result registers
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (memWrite) memory[request.target][wrIndex] <= wrData;
    if (sizeWrite) sizes[request.target] <= newSize;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= arrayHeapPkg::errNone;
    end else if (request.action != arrayHeapPkg::actNop) begin
      error <= stepError;                 // every command reports
      if (outWrite) out <= outValue;
    end
  end

endmodule

`default_nettype wire

/* hdl/heapAllocator.sv */
// hands out arrays, freed ones first in LIFO order, then never used ones
// rejects access to arrays that are not allocated, and double frees
// request outputs are combinational, state moves at the command's edge
`timescale 1ns/1ps
`default_nettype none
`include "arrayHeap_defines.svh"

module heapAllocator (
  input wire                              clock,
  input wire                              reset,
  input wire arrayHeapPkg::heapAction_t   action,
  input wire arrayHeapPkg::arrayId_t      array,
  input wire arrayHeapPkg::elementIndex_t index,
  input wire arrayHeapPkg::element_t      data,
  heapRequestIf.allocator                 request
);

  localparam int COUNT_BITS = `HEAP_ADDRESS_BITS + 1; // counts 0..HEAP_ARRAYS

  logic [arrayHeapPkg::HEAP_ARRAYS-1:0] allocated;              // one flag per array
  arrayHeapPkg::arrayId_t freeStack [arrayHeapPkg::HEAP_ARRAYS]; // freed array numbers
  logic [COUNT_BITS-1:0] freeTop;     // entries on the free stack
  logic [COUNT_BITS-1:0] freshCount;  // next never used array

  logic                   stackEmpty;
  logic                   freshLeft;
  logic [COUNT_BITS-1:0]  topLess;    // index of top entry
  arrayHeapPkg::arrayId_t chosen;     // array an alloc would get
  logic                   doAlloc;
  logic                   doFree;

  // --------------------------------------------------
  // choice of array for alloc
  // --------------------------------------------------
  assign stackEmpty = (freeTop == '0);
  assign freshLeft  = (freshCount < COUNT_BITS'(arrayHeapPkg::HEAP_ARRAYS));
  assign topLess    = freeTop - 1'b1;

  assign chosen = stackEmpty ? freshCount[`HEAP_ADDRESS_BITS-1:0]
                             : freeStack[topLess[`HEAP_ADDRESS_BITS-1:0]];

  assign doAlloc = (action == arrayHeapPkg::actAlloc) && (!stackEmpty || freshLeft);
  assign doFree  = (action == arrayHeapPkg::actFree) && allocated[array]; // no double free

  // --------------------------------------------------
  // request towards the store
  // --------------------------------------------------
  assign request.action = action;
  assign request.target = (action == arrayHeapPkg::actAlloc) ? chosen : array;
  assign request.index  = index;
  assign request.data   = data;

  always_comb begin
    request.allocError = arrayHeapPkg::errNone;
    if (action == arrayHeapPkg::actAlloc) begin
      if (stackEmpty && !freshLeft) begin
        request.allocError = arrayHeapPkg::errOutOfMemory; // all 8 in use
      end
    end else if (action != arrayHeapPkg::actNop && !allocated[array]) begin
      request.allocError = arrayHeapPkg::errNotAllocated; // also catches a second free
    end
  end

  // --------------------------------------------------
  // allocation state
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated  <= '0;
      freeTop    <= '0;
      freshCount <= '0;
    end else begin
      if (doAlloc) begin
        allocated[chosen] <= 1'b1;
        if (stackEmpty) begin
          freshCount <= freshCount + 1'b1;
        end else begin
          freeTop <= topLess;             // pop reused array
        end
      end
      if (doFree) begin
        allocated[array] <= 1'b0;
        freeTop          <= freeTop + 1'b1;
      end
    end
  end

  // stack body, only valid below freeTop
  always_ff @(posedge clock) begin
    if (doFree) begin
      freeStack[freeTop[`HEAP_ADDRESS_BITS-1:0]] <= array; // top < 8 while anything is allocated
    end
  end

endmodule

`default_nettype wire

/* hdl/heapRequestIf.sv */
// one decoded heap command, allocator to array store, purely combinational
// target is the chosen array on alloc, the addressed array otherwise
`timescale 1ns/1ps
`default_nettype none

interface heapRequestIf;

  arrayHeapPkg::heapAction_t   action;     // command of this cycle
  arrayHeapPkg::arrayId_t      target;     // array to work on
  arrayHeapPkg::elementIndex_t index;      // element within target
  arrayHeapPkg::element_t      data;       // input data
  arrayHeapPkg::heapError_t    allocError; // notAllocated / outOfMemory / none

  // --------------------------------------------------
  // allocator decodes, store executes
  // --------------------------------------------------
  modport allocator (
    output action, target, index, data, allocError
  );

  modport store (
    input action, target, index, data, allocError
  );

endinterface

`default_nettype wire

/* hdl/arrayHeapPkg.sv */
// action codes, error codes and element types of the array heap
// action codes keep the numbering of the older memory unit
`default_nettype none
`include "arrayHeap_defines.svh"

package arrayHeapPkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int HEAP_ARRAYS = 1 << `HEAP_ADDRESS_BITS; // arrays in the heap
  localparam int HEAP_LENGTH = 1 << `HEAP_INDEX_BITS;   // elements per array

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId_t;
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex_t;
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize_t;  // one more bit, holds 0..HEAP_LENGTH
  typedef logic [`HEAP_DATA_BITS-1:0]    element_t;

  // --------------------------------------------------
  // one action per clock, nop is idle
  // --------------------------------------------------
  typedef enum logic [4:0] {
    actNop      = 5'd0,
    actWrite    = 5'd2,
    actRead     = 5'd3,
    actSize     = 5'd4,
    actPush     = 5'd14,
    actPop      = 5'd15,
    actAlloc    = 5'd18,
    actFree     = 5'd19,
    actAdd      = 5'd20,  // returns new value
    actAddAfter = 5'd21,  // returns old value
    actSubtract = 5'd22,
    actOr       = 5'd28,
    actXor      = 5'd29,
    actAnd      = 5'd30
  } heapAction_t;

  // result of each command
  typedef enum logic [2:0] {
    errNone, errNotAllocated, errOutOfBounds, errFull, errEmpty, errOutOfMemory
  } heapError_t;

endpackage

`default_nettype wire

/* hdl/arrayHeap_defines.svh */
// geometry of the array heap, every other size is derived from these
// address and index bits set the memory depth, data bits only the element width
`ifndef ARRAYHEAP_DEFINES_SVH
`define ARRAYHEAP_DEFINES_SVH

// --------------------------------------------------
// array heap geometry
// --------------------------------------------------

// bits in an array number, 8 arrays
`define HEAP_ADDRESS_BITS 3

// bits in an element index, 4 elements per array
`define HEAP_INDEX_BITS   2

// width of one element, arithmetic wraps at this width
`define HEAP_DATA_BITS    12

`endif
